/* bench/agc_core_mem_checker.sv */
`timescale 1ns/1ps

module agc_core_mem_checker
  import agc_pkg::*;
(
  input logic       clk,
  input logic       rst_l,
  input logic       wr1_en,
  input reg_sel_t   wr1_sel,
  input logic       wr2_en,
  input reg_sel_t   wr2_sel,
  input word_t      wr2_data,
  input reg_sel_t   rs1_sel,
  input word_t      rs1_data,
  input reg_sel_t   rs2_sel,
  input word_t      rs2_data,
  input soft_addr_t rd_addr,
  input logic       rd_is_rom,
  input rom_addr_t  rd_rom_addr,
  input ram_addr_t  rd_ram_addr,
  input soft_addr_t wr_addr,
  input logic       mem_wr_en,
  input logic       ram_wr_en,
  input bank_t      eb,
  input bank_t      fb
);

  int fail_count = 0;

  zero_read: assert property (@(posedge clk) disable iff (!rst_l)
      (rs1_sel != ZERO || rs1_data == '0) && (rs2_sel != ZERO || rs2_data == '0))
    else begin
      fail_count++;
      $error("A read of ZERO returned a nonzero word");
    end

  // Forwarded word must match what the register holds after the edge
  forward_matches_store: assert property (@(posedge clk) disable iff (!rst_l)
      ((wr1_en && wr1_sel == rs1_sel) || (wr2_en && wr2_sel == rs1_sel))
      ##1 (!wr1_en && !wr2_en && $stable(rs1_sel)) |-> $stable(rs1_data))
    else begin
      fail_count++;
      $error("Forwarded read differs from the value stored after the write");
    end

  // A BB write on port 2 always lands in both fields
  bank_follows_write: assert property (@(posedge clk) disable iff (!rst_l)
      wr2_en && wr2_sel == BB |=>
      eb == $past(wr2_data[11:9]) && fb == $past(wr2_data[14:12]))
    else begin
      fail_count++;
      $error("Bank fields did not take the port 2 BB write");
    end

  region_select: assert property (@(posedge clk) disable iff (!rst_l)
      rd_is_rom == (rd_addr >= 12'o2000))
    else begin
      fail_count++;
      $error("Read region does not follow the ROM boundary");
    end

  unused_read_zero: assert property (@(posedge clk) disable iff (!rst_l)
      rd_is_rom ? rd_ram_addr == '0 : rd_rom_addr == '0)
    else begin
      fail_count++;
      $error("The unselected read address is not zero");
    end

  write_suppress: assert property (@(posedge clk) disable iff (!rst_l)
      ram_wr_en == (mem_wr_en && wr_addr < 12'o2000))
    else begin
      fail_count++;
      $error("Erasable write enable does not match the write region");
    end

endmodule

/* bench/tb_agc_core_mem.sv */
`timescale 1ns/1ps

module tb_agc_core_mem
  import agc_pkg::*;
();

  logic       clk = 1'b0;
  logic       rst_l;
  logic       wr1_en;
  logic       wr2_en;
  logic       mem_wr_en;
  reg_sel_t   wr1_sel;
  reg_sel_t   wr2_sel;
  reg_sel_t   rs1_sel;
  reg_sel_t   rs2_sel;
  word_t      wr1_data;
  word_t      wr2_data;
  soft_addr_t pc_addr;
  soft_addr_t rd_addr;
  soft_addr_t wr_addr;
  word_t      rs1_data;
  word_t      rs2_data;
  rom_addr_t  pc_rom_addr;
  rom_addr_t  rd_rom_addr;
  ram_addr_t  rd_ram_addr;
  ram_addr_t  ram_wr_addr;
  logic       rd_is_rom;
  logic       ram_wr_en;

  // Shadow of the register file, before and after the coming edge
  word_t       cur_regs [16];
  word_t       next_regs [16];
  bank_t       cur_eb;
  bank_t       cur_fb;
  bank_t       next_eb;
  bank_t       next_fb;
  logic [15:0] lfsr_state = 16'd97;
  int          errors = 0;
  int          checks = 0;
  string       test_name;
  soft_addr_t  sweep_addr [8] = '{12'o0, 12'o1377, 12'o1400, 12'o1777,
                                  12'o2000, 12'o3777, 12'o4000, 12'o7777};

  always #10 clk = ~clk;

  agc_core_mem uut (.*);

  bind agc_core_mem agc_core_mem_checker chk (.*);

  initial begin
    #50us;
    $display("Simulation ran past its time limit without finishing");
    $display("TESTS FAILED");
    $finish;
  end

  // x^16 + x^14 + x^13 + x^11 + 1
  function logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = {lfsr_state[14:0],
                    lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10]};
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  function automatic word_t expect_edit(input reg_sel_t sel, input word_t d);
    case (sel)
      CYR: return (d >> 1) | (d << 14);
      SR: return (d >> 1) | (d & 15'h4000);
      CYL: return (d << 1) | (d >> 14);
      SL: return d << 1;
      default: return d;
    endcase
  endfunction

  function automatic void apply_write(input logic en, input reg_sel_t sel, input word_t d);
    if (!en || sel == ZERO)
      return;
    if (sel == EB || sel == BB)
      next_eb = d[11:9];
    if (sel == FB || sel == BB)
      next_fb = d[14:12];
    if (sel != EB && sel != FB && sel != BB)
      next_regs[sel] = expect_edit(sel, d);
  endfunction

  function automatic word_t expect_view(input reg_sel_t sel, input bit after);
    bank_t e;
    bank_t f;
    e = after ? next_eb : cur_eb;
    f = after ? next_fb : cur_fb;
    case (sel)
      ZERO: return '0;
      EB: return word_t'(e) << 9;
      FB: return word_t'(f) << 12;
      BB: return (word_t'(f) << 12) | (word_t'(e) << 9);
      default: return after ? next_regs[sel] : cur_regs[sel];
    endcase
  endfunction

  function automatic bit written(input reg_sel_t sel);
    return (wr1_en && wr1_sel == sel) || (wr2_en && wr2_sel == sel);
  endfunction

  function automatic int expect_rom(input int a, input int f);
    if (a >= 'o4000)
      return a - 'o4000;
    return a + 'o2000 + f * 'o2000;
  endfunction

  function automatic int expect_ram(input int a, input int e);
    int off;
    off = (e >= 4) ? 'o2000 : (e % 4) * 'o400;
    if (a < 'o1400)
      off = 0;
    return (a + off) % 'o4000;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    assert (actual === expected)
    else begin
      errors++;
      $display("FAILED %s %s: expected %0h, actual %0h", test_name, name, expected, actual);
    end
  endtask

  // Compare every output just before the edge, then advance the shadow
  task automatic check_cycle();
    bit rom_rd;
    @(negedge clk);
    next_regs = cur_regs;
    next_eb = cur_eb;
    next_fb = cur_fb;
    apply_write(wr1_en, wr1_sel, wr1_data);
    apply_write(wr2_en, wr2_sel, wr2_data);
    rom_rd = rd_addr >= 'o2000;
    check_value("rs1_data", expect_view(rs1_sel, written(rs1_sel)), rs1_data);
    check_value("rs2_data", expect_view(rs2_sel, written(rs2_sel)), rs2_data);
    check_value("pc_rom_addr", expect_rom(pc_addr, cur_fb), pc_rom_addr);
    check_value("rd_is_rom", rom_rd, rd_is_rom);
    check_value("rd_rom_addr", rom_rd ? expect_rom(rd_addr, cur_fb) : 0, rd_rom_addr);
    check_value("rd_ram_addr", rom_rd ? 0 : expect_ram(rd_addr, cur_eb), rd_ram_addr);
    check_value("ram_wr_addr", expect_ram(wr_addr, cur_eb), ram_wr_addr);
    check_value("ram_wr_en", mem_wr_en && wr_addr < 'o2000, ram_wr_en);
    @(posedge clk);
    cur_regs = next_regs;
    cur_eb = next_eb;
    cur_fb = next_fb;
    #2;
  endtask

  task automatic drive_idle();
    wr1_en = 1'b0;
    wr2_en = 1'b0;
    mem_wr_en = 1'b0;
    wr1_sel = A;
    wr2_sel = A;
    rs1_sel = A;
    rs2_sel = A;
    wr1_data = '0;
    wr2_data = '0;
    pc_addr = '0;
    rd_addr = '0;
    wr_addr = '0;
  endtask

  // Selects are biased so that both ports and reads often collide
  task automatic drive_random();
    wr1_en = rand_bits(1) != 0;
    wr1_sel = reg_sel_t'(rand_bits(4) % 13);
    wr1_data = word_t'(rand_bits(15));
    wr2_en = rand_bits(1) != 0;
    wr2_sel = (rand_bits(2) == 0) ? wr1_sel : reg_sel_t'(rand_bits(4) % 13);
    wr2_data = word_t'(rand_bits(15));
    rs1_sel = (rand_bits(1) != 0) ? wr2_sel : reg_sel_t'(rand_bits(4) % 13);
    rs2_sel = (rand_bits(1) != 0) ? wr1_sel : reg_sel_t'(rand_bits(4) % 13);
    pc_addr = soft_addr_t'(rand_bits(12));
    rd_addr = soft_addr_t'(rand_bits(12));
    wr_addr = soft_addr_t'(rand_bits(12));
    mem_wr_en = rand_bits(1) != 0;
  endtask

  task automatic wait_reset_done();
    int n;
    n = 0;
    while (rs1_data !== '0 || ram_wr_en !== 1'b0) begin
      if (n == 16) begin
        errors++;
        $display("Timed out waiting for the DUT outputs to settle after reset");
        return;
      end
      @(posedge clk);
      #2;
      n++;
    end
  endtask

  initial begin
    rst_l = 1'b0;
    drive_idle();
    foreach (cur_regs[i])
      cur_regs[i] = '0;
    cur_eb = '0;
    cur_fb = '0;
    repeat (8) @(posedge clk);
    #2;
    rst_l = 1'b1;
    wait_reset_done();

    test_name = "reset";
    for (int s = 0; s < 13; s++) begin
      rs1_sel = reg_sel_t'(s);
      rs2_sel = reg_sel_t'(12 - s);
      check_cycle();
    end

    // Load each fixed-bank value, then sweep the region boundaries
    test_name = "bank sweep";
    for (int k = 0; k < 8; k++) begin
      drive_idle();
      wr1_en = 1'b1;
      wr1_sel = BB;
      wr1_data = word_t'((k << 12) | ((7 - k) << 9));
      rs1_sel = BB;
      check_cycle();
      drive_idle();
      rs1_sel = EB;
      rs2_sel = FB;
      foreach (sweep_addr[i]) begin
        pc_addr = sweep_addr[i];
        rd_addr = sweep_addr[7 - i];
        wr_addr = sweep_addr[i];
        mem_wr_en = 1'b1;
        check_cycle();
      end
    end

    // Both ports hit the read register, then one quiet cycle
    test_name = "forwarding";
    for (int s = 0; s < 13; s++) begin
      drive_idle();
      wr1_en = 1'b1;
      wr1_sel = reg_sel_t'(s);
      wr1_data = word_t'(rand_bits(15));
      wr2_en = 1'b1;
      wr2_sel = reg_sel_t'(s);
      wr2_data = word_t'(rand_bits(15));
      rs1_sel = reg_sel_t'(s);
      rs2_sel = reg_sel_t'(s);
      check_cycle();
      wr1_en = 1'b0;
      wr2_en = 1'b0;
      check_cycle();
    end

    test_name = "random";
    repeat (300) begin
      drive_random();
      check_cycle();
    end

    $display("Checks %0d, mismatches %0d, assertion failures %0d",
             checks, errors, uut.chk.fail_count);
    if (errors == 0 && uut.chk.fail_count == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

endmodule

/* common/agc_pkg.sv */
package agc_pkg;

  localparam int word_w = 15;

  typedef logic [word_w-1:0] word_t;
  typedef logic [11:0] soft_addr_t;
  typedef logic [13:0] rom_addr_t;
  typedef logic [10:0] ram_addr_t;
  typedef logic [2:0] bank_t;

  // Central register select codes
  typedef enum logic [3:0] {
    A, L, Q, EB, FB, BB, ZERO, CYR, SR, CYL, SL, TIME1, TIME2
  } reg_sel_t;

  // Software memory map, in octal as the machine documents it
  localparam soft_addr_t rom_region_base = 12'o2000;
  localparam soft_addr_t fixed_rom_base = 12'o4000;
  localparam rom_addr_t bank_rom_size = 14'o2000;
  localparam soft_addr_t fixed_ram_limit = 12'o1400;
  localparam ram_addr_t bank_ram_size = 11'o400;
  localparam ram_addr_t eb_high_offset = 11'o2000;

  // Bank fields inside a data word
  localparam int eb_lsb = 9;
  localparam int fb_lsb = 12;

  // Value held by a register after a write of data
  function automatic word_t edit_on_write(input reg_sel_t sel, input word_t data);
    word_t edited;
    case (sel)
      CYR: edited = {data[0], data[word_w-1:1]};
      // Sign bit is copied into the top
      SR: edited = {data[word_w-1], data[word_w-1:1]};
      CYL: edited = {data[word_w-2:0], data[word_w-1]};
      SL: edited = {data[word_w-2:0], 1'b0};
      default: edited = data;
    endcase
    return edited;
  endfunction

  // Word seen when reading a bank register
  function automatic word_t bank_view(input reg_sel_t sel, input bank_t eb, input bank_t fb);
    word_t view;
    view = '0;
    if (sel == EB || sel == BB) begin
      view[eb_lsb +: $bits(bank_t)] = eb;
    end
    if (sel == FB || sel == BB) begin
      view[fb_lsb +: $bits(bank_t)] = fb;
    end
    return view;
  endfunction

endpackage

/* regfile/central_regs.sv */
`timescale 1ns/1ps

module central_regs
  import agc_pkg::*;
(
  input  logic     clk,
  input  logic     rst_l,
  input  logic     wr1_en,
  input  reg_sel_t wr1_sel,
  input  word_t    wr1_data,
  input  logic     wr2_en,
  input  reg_sel_t wr2_sel,
  input  word_t    wr2_data,
  output word_t    stored_a,
  output word_t    stored_l,
  output word_t    stored_q,
  output word_t    stored_bank,
  output word_t    stored_cyr,
  output word_t    stored_sr,
  output word_t    stored_cyl,
  output word_t    stored_sl,
  output word_t    stored_time1,
  output word_t    stored_time2,
  output bank_t    eb,
  output bank_t    fb
);

  logic [1:0] port_en;
  reg_sel_t   port_sel [2];
  word_t      port_data [2];
  word_t      port_edit [2];

  // Port 0 is write port 1, port 1 is write port 2
  assign port_en = {wr2_en, wr1_en};
  assign port_sel[0] = wr1_sel;
  assign port_sel[1] = wr2_sel;
  assign port_data[0] = wr1_data;
  assign port_data[1] = wr2_data;

  // Editing registers keep the shifted word
  assign port_edit[0] = edit_on_write(wr1_sel, wr1_data);
  assign port_edit[1] = edit_on_write(wr2_sel, wr2_data);

  always_ff @(posedge clk or negedge rst_l) begin
    if (!rst_l) begin
      stored_a <= '0;
      stored_l <= '0;
      stored_q <= '0;
      stored_cyr <= '0;
      stored_sr <= '0;
      stored_cyl <= '0;
      stored_sl <= '0;
      stored_time1 <= '0;
      stored_time2 <= '0;
      eb <= '0;
      fb <= '0;
    end else begin
      // Port 2 is visited last so it takes precedence
      for (int p = 0; p < 2; p++) begin
        if (port_en[p]) begin
          case (port_sel[p])
            A: stored_a <= port_edit[p];
            L: stored_l <= port_edit[p];
            Q: stored_q <= port_edit[p];
            // Bank writes touch only their own field
            EB: eb <= port_data[p][eb_lsb +: $bits(bank_t)];
            FB: fb <= port_data[p][fb_lsb +: $bits(bank_t)];
            BB: begin
              eb <= port_data[p][eb_lsb +: $bits(bank_t)];
              fb <= port_data[p][fb_lsb +: $bits(bank_t)];
            end
            CYR: stored_cyr <= port_edit[p];
            SR: stored_sr <= port_edit[p];
            CYL: stored_cyl <= port_edit[p];
            SL: stored_sl <= port_edit[p];
            TIME1: stored_time1 <= port_edit[p];
            TIME2: stored_time2 <= port_edit[p];
            // ZERO and unused codes are dropped
            default: ;
          endcase
        end
      end
    end
  end

  // Only the six bank bits are stored
  assign stored_bank = bank_view(BB, eb, fb);

endmodule

/* regfile/reg_read_port.sv */
`timescale 1ns/1ps

module reg_read_port
  import agc_pkg::*;
(
  input  reg_sel_t rs_sel,
  input  logic     wr1_en,
  input  reg_sel_t wr1_sel,
  input  word_t    wr1_data,
  input  logic     wr2_en,
  input  reg_sel_t wr2_sel,
  input  word_t    wr2_data,
  input  word_t    stored_a,
  input  word_t    stored_l,
  input  word_t    stored_q,
  input  word_t    stored_bank,
  input  word_t    stored_cyr,
  input  word_t    stored_sr,
  input  word_t    stored_cyl,
  input  word_t    stored_sl,
  input  word_t    stored_time1,
  input  word_t    stored_time2,
  input  bank_t    eb,
  input  bank_t    fb,
  output word_t    rs_data
);

  word_t stored;
  logic  live;
  logic  is_bank;
  logic  hit1;
  logic  hit2;
  bank_t fwd_eb;
  bank_t fwd_fb;

  always_comb begin
    live = 1'b1;
    is_bank = 1'b0;
    case (rs_sel)
      A: stored = stored_a;
      L: stored = stored_l;
      Q: stored = stored_q;
      EB, FB: begin
        stored = bank_view(rs_sel, eb, fb);
        is_bank = 1'b1;
      end
      BB: begin
        stored = stored_bank;
        is_bank = 1'b1;
      end
      CYR: stored = stored_cyr;
      SR: stored = stored_sr;
      CYL: stored = stored_cyl;
      SL: stored = stored_sl;
      TIME1: stored = stored_time1;
      TIME2: stored = stored_time2;
      // ZERO and unused codes never forward
      default: begin
        stored = '0;
        live = 1'b0;
      end
    endcase

    hit1 = live && wr1_en && (wr1_sel == rs_sel);
    hit2 = live && wr2_en && (wr2_sel == rs_sel);

    // Bank fields as they will be after the edge, port 2 last
    fwd_eb = eb;
    fwd_fb = fb;
    if (wr1_en && (wr1_sel == EB || wr1_sel == BB))
      fwd_eb = wr1_data[eb_lsb +: $bits(bank_t)];
    if (wr1_en && (wr1_sel == FB || wr1_sel == BB))
      fwd_fb = wr1_data[fb_lsb +: $bits(bank_t)];
    if (wr2_en && (wr2_sel == EB || wr2_sel == BB))
      fwd_eb = wr2_data[eb_lsb +: $bits(bank_t)];
    if (wr2_en && (wr2_sel == FB || wr2_sel == BB))
      fwd_fb = wr2_data[fb_lsb +: $bits(bank_t)];

    if (is_bank && (hit1 || hit2))
      rs_data = bank_view(rs_sel, fwd_eb, fwd_fb);
    else if (hit2)
      rs_data = edit_on_write(wr2_sel, wr2_data);
    else if (hit1)
      rs_data = edit_on_write(wr1_sel, wr1_data);
    else
      rs_data = stored;
  end

endmodule

/* source/agc_core_mem.sv */
`timescale 1ns/1ps

module agc_core_mem
  import agc_pkg::*;
(
  input  logic       clk,
  input  logic       rst_l,
  input  logic       wr1_en,
  input  reg_sel_t   wr1_sel,
  input  word_t      wr1_data,
  input  logic       wr2_en,
  input  reg_sel_t   wr2_sel,
  input  word_t      wr2_data,
  input  reg_sel_t   rs1_sel,
  input  reg_sel_t   rs2_sel,
  input  soft_addr_t pc_addr,
  input  soft_addr_t rd_addr,
  input  soft_addr_t wr_addr,
  input  logic       mem_wr_en,
  output word_t      rs1_data,
  output word_t      rs2_data,
  output rom_addr_t  pc_rom_addr,
  output logic       rd_is_rom,
  output rom_addr_t  rd_rom_addr,
  output ram_addr_t  rd_ram_addr,
  output ram_addr_t  ram_wr_addr,
  output logic       ram_wr_en
);

  word_t stored_a;
  word_t stored_l;
  word_t stored_q;
  word_t stored_bank;
  word_t stored_cyr;
  word_t stored_sr;
  word_t stored_cyl;
  word_t stored_sl;
  word_t stored_time1;
  word_t stored_time2;
  bank_t eb;
  bank_t fb;

  central_regs regs (
    .clk, .rst_l,
    .wr1_en, .wr1_sel, .wr1_data,
    .wr2_en, .wr2_sel, .wr2_data,
    .stored_a, .stored_l, .stored_q, .stored_bank,
    .stored_cyr, .stored_sr, .stored_cyl, .stored_sl,
    .stored_time1, .stored_time2,
    .eb, .fb
  );

  reg_read_port read_port_1 (
    .rs_sel (rs1_sel),
    .wr1_en, .wr1_sel, .wr1_data,
    .wr2_en, .wr2_sel, .wr2_data,
    .stored_a, .stored_l, .stored_q, .stored_bank,
    .stored_cyr, .stored_sr, .stored_cyl, .stored_sl,
    .stored_time1, .stored_time2,
    .eb, .fb,
    .rs_data (rs1_data)
  );

  reg_read_port read_port_2 (
    .rs_sel (rs2_sel),
    .wr1_en, .wr1_sel, .wr1_data,
    .wr2_en, .wr2_sel, .wr2_data,
    .stored_a, .stored_l, .stored_q, .stored_bank,
    .stored_cyr, .stored_sr, .stored_cyl, .stored_sl,
    .stored_time1, .stored_time2,
    .eb, .fb,
    .rs_data (rs2_data)
  );

  // Registered bank bits steer translation
  addr_translate xlate (
    .pc_addr, .rd_addr, .wr_addr, .mem_wr_en,
    .eb, .fb,
    .pc_rom_addr, .rd_is_rom, .rd_rom_addr, .rd_ram_addr,
    .ram_wr_addr, .ram_wr_en
  );

endmodule

/* translate/addr_translate.sv */
`timescale 1ns/1ps

module addr_translate
  import agc_pkg::*;
(
  input  soft_addr_t pc_addr,
  input  soft_addr_t rd_addr,
  input  soft_addr_t wr_addr,
  input  logic       mem_wr_en,
  input  bank_t      eb,
  input  bank_t      fb,
  output rom_addr_t  pc_rom_addr,
  output logic       rd_is_rom,
  output rom_addr_t  rd_rom_addr,
  output ram_addr_t  rd_ram_addr,
  output ram_addr_t  ram_wr_addr,
  output logic       ram_wr_en
);

  rom_addr_t rd_rom_full;
  ram_addr_t rd_ram_full;

  // Instruction fetch always targets ROM
  rom_translate fetch_rom (
    .soft_addr (pc_addr),
    .fb        (fb),
    .rom_addr  (pc_rom_addr)
  );

  rom_translate read_rom (
    .soft_addr (rd_addr),
    .fb        (fb),
    .rom_addr  (rd_rom_full)
  );

  ram_translate read_ram (
    .soft_addr (rd_addr),
    .eb        (eb),
    .ram_addr  (rd_ram_full)
  );

  ram_translate write_ram (
    .soft_addr (wr_addr),
    .eb        (eb),
    .ram_addr  (ram_wr_addr)
  );

  // Read region, the other address reads zero
  assign rd_is_rom = rd_addr >= rom_region_base;
  assign rd_rom_addr = rd_is_rom ? rd_rom_full : '0;
  assign rd_ram_addr = rd_is_rom ? '0 : rd_ram_full;

  // ROM is read only
  assign ram_wr_en = mem_wr_en && (wr_addr < rom_region_base);

endmodule

/* translate/ram_translate.sv */
`timescale 1ns/1ps

module ram_translate
  import agc_pkg::*;
(
  input  soft_addr_t soft_addr,
  input  bank_t      eb,
  output ram_addr_t  ram_addr
);

  logic      is_fixed;
  ram_addr_t low_off;
  ram_addr_t bank_off;
  ram_addr_t base_addr;

  always_comb begin
    is_fixed = soft_addr < fixed_ram_limit;
    base_addr = soft_addr[$bits(ram_addr_t)-1:0];

    // Low two EB bits pick one of four banks
    case (eb[1:0])
      2'd0: low_off = '0;
      2'd1: low_off = bank_ram_size;
      2'd2: low_off = ram_addr_t'(2) * bank_ram_size;
      default: low_off = ram_addr_t'(3) * bank_ram_size;
    endcase

    // Top EB bit overrides with the high half
    bank_off = eb[2] ? eb_high_offset : low_off;

    if (is_fixed)
      ram_addr = base_addr;
    else
      ram_addr = base_addr + bank_off;
  end

endmodule

/* translate/rom_translate.sv */
`timescale 1ns/1ps

module rom_translate
  import agc_pkg::*;
(
  input  soft_addr_t soft_addr,
  input  bank_t      fb,
  output rom_addr_t  rom_addr
);

  logic      is_fixed;
  rom_addr_t fixed_addr;
  rom_addr_t bank_off;
  rom_addr_t banked_addr;

  always_comb begin
    is_fixed = soft_addr >= fixed_rom_base;
    fixed_addr = rom_addr_t'(soft_addr - fixed_rom_base);

    // Bank offset table, avoids a multiplier
    case (fb)
      3'd0: bank_off = '0;
      3'd1: bank_off = bank_rom_size;
      3'd2: bank_off = rom_addr_t'(2) * bank_rom_size;
      3'd3: bank_off = rom_addr_t'(3) * bank_rom_size;
      3'd4: bank_off = rom_addr_t'(4) * bank_rom_size;
      3'd5: bank_off = rom_addr_t'(5) * bank_rom_size;
      3'd6: bank_off = rom_addr_t'(6) * bank_rom_size;
      default: bank_off = rom_addr_t'(7) * bank_rom_size;
    endcase

    // Banks start above the two fixed banks
    banked_addr = rom_addr_t'(soft_addr) + rom_addr_t'(rom_region_base) + bank_off;

    rom_addr = is_fixed ? fixed_addr : banked_addr;
  end

endmodule

/* verilog.f */
common/agc_pkg.sv
regfile/central_regs.sv
regfile/reg_read_port.sv
translate/rom_translate.sv
translate/ram_translate.sv
translate/addr_translate.sv
source/agc_core_mem.sv
bench/agc_core_mem_checker.sv
bench/tb_agc_core_mem.sv
